//--- tb.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_op_decode.sv
logic/csr_regs.sv
logic/trap_ctrl.sv
logic/hw_trigger.sv
logic/csr_unit.sv
dv/tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/csr_pkg.sv
      - logic/csr_op_decode.sv
      - logic/csr_regs.sv
      - logic/trap_ctrl.sv
      - logic/hw_trigger.sv
      - logic/csr_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_csr_unit.sv

//--- dv/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module tb_csr_unit
  import csr_pkg::*;
();

  localparam int NSTEPS = 16;
  localparam int NRAND  = 40;
  localparam int GAP    = 10;  // mcycle read spacing

  logic             clk_i;
  logic             rst_ni;
  logic             csr_req_i;
  csr_op_e          csr_op_i;
  logic [11:0]      csr_addr_i;
  logic [`XLEN-1:0] csr_src_i, csr_rdata_o;
  logic             exc_i;
  exc_cause_e       exc_cause_i;
  logic [`XLEN-1:0] exc_pc_i, exc_tval_i;
  logic             retire_i, mret_i;
  logic [`XLEN-1:0] retire_pc_i;
  logic             trap_o, redirect_o, misa_c_o;
  logic [`XLEN-1:0] redirect_pc_o;

  logic [31:0] s_rdata, s_rpc;  // Sampled at negedge
  logic        s_trap, s_redir;
  integer      errors, checks, seed, i, k;
  logic [31:0] src, c0, c1;
  csr_op_e     op;

  csr_op_e     t_op [NSTEPS];    // Step table
  logic [11:0] t_addr [NSTEPS];
  logic [31:0] t_src [NSTEPS];
  logic [31:0] t_exp [NSTEPS];
  string       t_name [NSTEPS];
  int          n_steps;
  logic [11:0] m_addr [7];       // Shadow model of the random targets
  logic [31:0] m_val [7];
  csr_op_e     ops [6];

  csr_unit dut (
    .clk_i, .rst_ni, .csr_req_i, .csr_op_i, .csr_addr_i, .csr_src_i, .csr_rdata_o,
    .exc_i, .exc_cause_i, .exc_pc_i, .exc_tval_i, .retire_i, .retire_pc_i, .mret_i,
    .trap_o, .redirect_o, .redirect_pc_o, .misa_c_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic idle_inputs();
    csr_req_i   = 1'b0;
    csr_op_i    = CSR_NONE;
    csr_addr_i  = '0;
    csr_src_i   = '0;
    exc_i       = 1'b0;
    exc_cause_i = EXC_IADDR_MISALIGN;
    exc_pc_i    = '0;
    exc_tval_i  = '0;
    retire_i    = 1'b0;
    retire_pc_i = '0;
    mret_i      = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    int c;
    for (c = 0; c < n; c++) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // Sample mid-cycle, then back to idle 2 ns past the edge
  task automatic end_cycle();
    @(negedge clk_i);
    s_rdata = csr_rdata_o;
    s_trap  = trap_o;
    s_redir = redirect_o;
    s_rpc   = redirect_pc_o;
    @(posedge clk_i);
    #2;
    idle_inputs();
  endtask

  task automatic csr_access(input csr_op_e o, input logic [11:0] addr, input logic [31:0] s);
    csr_req_i  = 1'b1;
    csr_op_i   = o;
    csr_addr_i = addr;
    csr_src_i  = s;
    end_cycle();
  endtask

  task automatic csr_read(input logic [11:0] addr);
    csr_access(CSR_RS, addr, '0);  // rs with x0 never writes
  endtask

  task automatic retire_at(input logic [31:0] pc);
    retire_i    = 1'b1;
    retire_pc_i = pc;
    end_cycle();
  endtask

  task automatic trap_regs(input string name, input int cause, input logic [31:0] epc,
                           input logic [31:0] tval);
    csr_read(`CSR_MCAUSE);
    check({name, "_mcause"}, cause, s_rdata);
    csr_read(`CSR_MEPC);
    check({name, "_mepc"}, epc, s_rdata);
    csr_read(`CSR_MTVAL);
    check({name, "_mtval"}, tval, s_rdata);
  endtask

  task automatic wait_quiet(input int limit);
    int n;
    n = 0;
    while ((trap_o || redirect_o) && n < limit) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (trap_o || redirect_o) begin
      $display("Timeout: trap or redirect still active after reset");
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  task automatic add_step(input csr_op_e o, input logic [11:0] addr, input logic [31:0] s,
                          input logic [31:0] exp, input string name);
    t_op[n_steps]   = o;
    t_addr[n_steps] = addr;
    t_src[n_steps]  = s;
    t_exp[n_steps]  = exp;
    t_name[n_steps] = name;
    n_steps++;
  endtask

  // Expected CSR semantics from the ISA and the WARL rules
  function automatic logic [31:0] operand(input csr_op_e o, input logic [31:0] s);
    if (o == CSR_RWI || o == CSR_RSI || o == CSR_RCI) return {27'b0, s[4:0]};
    return s;
  endfunction

  function automatic logic [31:0] new_value(input csr_op_e o, input logic [31:0] s,
                                            input logic [31:0] old);
    if (o == CSR_RS || o == CSR_RSI) return old | operand(o, s);
    if (o == CSR_RC || o == CSR_RCI) return old & ~operand(o, s);
    return operand(o, s);
  endfunction

  function automatic logic [31:0] legalize(input logic [11:0] addr, input logic [31:0] w,
                                           input logic [31:0] old);
    case (addr)
      `CSR_MSTATUS: return 32'h0000_1800 | (w & 32'h88);  // MPP reads 3
      `CSR_MIE:     return w & `MIE_WMASK;
      `CSR_MISA:    return (old & ~`MISA_WMASK) | (w & `MISA_WMASK);
      `CSR_TDATA1:  return 32'h2000_0000 | (w & 32'h44);  // Type 2, m and execute
      default:      return w;
    endcase
  endfunction

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    errors  = 0;
    checks  = 0;
    n_steps = 0;
    seed    = 32'h4b17;
    rst_ni  = 1'b0;
    idle_inputs();
    idle_cycles(5);
    rst_ni = 1'b1;
    wait_quiet(20);

    // Reset values and fixed WARL cases; rdata is always the old value
    add_step(CSR_RS,  `CSR_MISA,    32'h0,         32'h4000_1104, "misa_reset");
    add_step(CSR_RS,  `CSR_TDATA1,  32'h0,         32'h2000_0044, "tdata1_reset");
    add_step(CSR_RS,  `CSR_MSTATUS, 32'h0,         32'h0000_1800, "mstatus_reset");
    add_step(CSR_RW,  `CSR_MSTATUS, 32'hffff_ffff, 32'h0000_1800, "mstatus_rw_all");
    add_step(CSR_RS,  `CSR_MSTATUS, 32'h0,         32'h0000_1888, "mstatus_warl");
    add_step(CSR_RW,  `CSR_MIE,     32'hffff_ffff, 32'h0,         "mie_rw_all");
    add_step(CSR_RCI, `CSR_MIE,     32'h8,         32'h0000_0888, "mie_warl");
    add_step(CSR_RS,  `CSR_MIE,     32'h0,         32'h0000_0880, "mie_rci");
    add_step(CSR_RW,  `CSR_MISA,    32'h0,         32'h4000_1104, "misa_rw_zero");
    add_step(CSR_RSI, `CSR_MISA,    32'h0,         32'h4000_1100, "misa_c_clear");
    add_step(CSR_RW,  `CSR_TDATA1,  32'hffff_ffff, 32'h2000_0044, "tdata1_rw_all");
    add_step(CSR_RC,  `CSR_TDATA1,  32'h0000_0040, 32'h2000_0044, "tdata1_warl");
    add_step(CSR_RS,  `CSR_TDATA1,  32'h0,         32'h2000_0004, "tdata1_rc");
    add_step(CSR_RW,  `CSR_MIP,     32'hffff_ffff, 32'h0,         "mip_rw");
    add_step(CSR_RS,  `CSR_MIP,     32'h0,         32'h0,         "mip_zero");
    add_step(CSR_RS,  `CSR_MHARTID, 32'h0,         32'h0,         "mhartid_read");
    for (i = 0; i < n_steps; i++) begin
      csr_access(t_op[i], t_addr[i], t_src[i]);
      check(t_name[i], t_exp[i], s_rdata);
      check({t_name[i], "_notrap"}, 0, s_trap);
    end
    check("misa_c_o", 0, misa_c_o);

    // Random rw/rs/rc traffic against the shadow model
    m_addr = '{`CSR_MSCRATCH, `CSR_MIE, `CSR_MISA, `CSR_MSTATUS, `CSR_TDATA1,
               `CSR_MTVEC, `CSR_PMPADDR0};
    m_val  = '{32'h0, 32'h880, 32'h4000_1100, 32'h1888, 32'h2000_0004, 32'h0, 32'h0};
    ops    = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    for (i = 0; i < NRAND; i++) begin
      k   = $unsigned($random(seed)) % 7;
      op  = ops[$unsigned($random(seed)) % 6];
      src = $random(seed);
      csr_access(op, m_addr[k], src);
      check($sformatf("rand_%0d", i), m_val[k], s_rdata);
      if (op == CSR_RW || op == CSR_RWI || operand(op, src) != 0) begin  // rs/rc x0 skip
        m_val[k] = legalize(m_addr[k], new_value(op, src, m_val[k]), m_val[k]);
      end
    end
    for (k = 0; k < 7; k++) begin
      csr_read(m_addr[k]);
      check($sformatf("rand_final_%03h", m_addr[k]), m_val[k], s_rdata);
    end

    // ==========================================================
    // Illegal CSR accesses
    // ==========================================================
    csr_access(CSR_RW, `CSR_MTVEC, 32'h8000_1003);
    exc_pc_i = 32'h200;
    csr_access(CSR_RW, 12'h7C0, 32'hdead_beef);  // Unimplemented
    check("unimpl_trap", 1, s_trap);
    check("unimpl_target", 32'h8000_1000, s_rpc);
    trap_regs("unimpl", 2, 32'h200, 32'h7C0);
    exc_pc_i = 32'h204;
    csr_access(CSR_RW, `CSR_MVENDORID, 32'h1234);  // Read-only space
    check("ro_trap", 1, s_trap);
    trap_regs("ro", 2, 32'h204, 32'hF11);
    csr_read(`CSR_MVENDORID);
    check("ro_unchanged", 0, s_rdata);
    exc_pc_i = 32'h208;
    csr_access(CSR_RSI, `CSR_CYCLEH, 32'h5);
    check("cycleh_trap", 1, s_trap);
    trap_regs("cycleh", 2, 32'h208, 32'hC80);
    csr_read(`CSR_CYCLEH);
    check("cycleh_unchanged", 0, s_rdata);

    // External exception then MRET
    csr_access(CSR_RW, `CSR_MSTATUS, 32'h8);  // mie=1 mpie=0
    exc_i       = 1'b1;
    exc_cause_i = EXC_ECALL_M;
    exc_pc_i    = 32'h300;
    exc_tval_i  = 32'h1234;
    end_cycle();
    check("exc_trap", 1, s_trap);
    check("exc_target", 32'h8000_1000, s_rpc);
    trap_regs("exc", 11, 32'h300, 32'h1234);
    csr_read(`CSR_MSTATUS);
    check("exc_mstatus", 32'h1880, s_rdata);
    mret_i = 1'b1;
    end_cycle();
    check("mret_redirect", 1, s_redir);
    check("mret_target", 32'h300, s_rpc);
    csr_read(`CSR_MSTATUS);
    check("mret_mstatus", 32'h1888, s_rdata);

    // ==========================================================
    // Execute breakpoint
    // ==========================================================
    csr_access(CSR_RW, `CSR_TDATA2, 32'h400);
    csr_access(CSR_RW, `CSR_TDATA1, 32'h44);
    csr_access(CSR_RW, `CSR_TCONTROL, 32'h8);  // mte
    retire_at(32'h3FC);
    check("bp_miss_pc", 0, s_trap);
    retire_at(32'h400);
    check("bp_hit", 1, s_trap);
    check("bp_target", 32'h8000_1000, s_rpc);
    trap_regs("bp", 3, 32'h400, 32'h400);
    csr_read(`CSR_TCONTROL);
    check("bp_tcontrol", 32'h80, s_rdata);
    retire_at(32'h400);
    check("bp_mte_clear", 0, s_trap);
    mret_i = 1'b1;
    end_cycle();
    check("bp_mret_target", 32'h400, s_rpc);
    csr_read(`CSR_TCONTROL);
    check("bp_mret_tcontrol", 32'h08, s_rdata);
    retire_at(32'h400);
    check("bp_rearmed", 1, s_trap);

    // Counters and user aliases
    csr_read(`CSR_MCYCLE);
    c0 = s_rdata;
    idle_cycles(GAP - 1);
    csr_read(`CSR_MCYCLE);
    check("mcycle_gap", GAP, s_rdata - c0);
    csr_read(`CSR_MINSTRET);
    c0 = s_rdata;
    for (i = 0; i < 5; i++) retire_at(32'h500 + 4 * i);
    for (i = 0; i < 2; i++) begin
      exc_i       = 1'b1;  // Trapping retire, not counted
      exc_cause_i = EXC_LACCESS;
      exc_pc_i    = 32'h600;
      retire_at(32'h600);
      check("retire_exc_trap", 1, s_trap);
    end
    csr_read(`CSR_MINSTRET);
    c1 = s_rdata;
    check("minstret_count", 5, c1 - c0);
    csr_read(`CSR_INSTRET);
    check("instret_alias", c1, s_rdata);
    csr_read(`CSR_MINSTRETH);
    c1 = s_rdata;
    csr_read(`CSR_INSTRETH);
    check("instreth_alias", c1, s_rdata);
    csr_read(`CSR_MCYCLE);
    c1 = s_rdata;
    csr_read(`CSR_CYCLE);
    check("cycle_alias", c1 + 1, s_rdata);  // One cycle later
    csr_read(`CSR_MCYCLEH);
    c1 = s_rdata;
    csr_read(`CSR_CYCLEH);
    check("cycleh_alias", c1, s_rdata);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_unit
  import csr_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             csr_req_i,
  input  csr_op_e          csr_op_i,
  input  logic [11:0]      csr_addr_i,
  input  logic [`XLEN-1:0] csr_src_i,
  output logic [`XLEN-1:0] csr_rdata_o,
  input  logic             exc_i,
  input  exc_cause_e       exc_cause_i,
  input  logic [`XLEN-1:0] exc_pc_i,
  input  logic [`XLEN-1:0] exc_tval_i,
  input  logic             retire_i,
  input  logic [`XLEN-1:0] retire_pc_i,
  input  logic             mret_i,
  output logic             trap_o,
  output logic             redirect_o,
  output logic [`XLEN-1:0] redirect_pc_o,
  output logic             misa_c_o
);

  // ==========================================================
  // Internal nets
  // ==========================================================
  logic             csr_we;
  logic [`XLEN-1:0] csr_wdata;
  logic             csr_illegal;
  exc_cause_e       trap_cause;
  logic [`XLEN-1:0] trap_epc;
  logic [`XLEN-1:0] trap_tval;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  tdata1_u          tdata1;
  logic [`XLEN-1:0] tdata2;
  logic             mte;
  logic             bp_hit;

  csr_op_decode u_decode (
    .csr_req_i   (csr_req_i),
    .csr_op_i    (csr_op_i),
    .csr_src_i   (csr_src_i),
    .csr_old_i   (csr_rdata_o),  // Read-modify-write on the old value
    .csr_we_o    (csr_we),
    .csr_wdata_o (csr_wdata)
  );

  csr_regs u_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_addr_i    (csr_addr_i),
    .csr_req_i     (csr_req_i),
    .csr_we_i      (csr_we),
    .csr_wdata_i   (csr_wdata),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal),
    .trap_i        (trap_o),
    .trap_cause_i  (trap_cause),
    .trap_epc_i    (trap_epc),
    .trap_tval_i   (trap_tval),
    .mret_i        (mret_i),
    .retire_i      (retire_i),
    .mtvec_o       (mtvec),
    .mepc_o        (mepc),
    .misa_c_o      (misa_c_o),
    .tdata1_o      (tdata1),
    .tdata2_o      (tdata2),
    .mte_o         (mte)
  );

  hw_trigger u_trigger (
    .retire_i    (retire_i),
    .retire_pc_i (retire_pc_i),
    .tdata1_i    (tdata1),
    .tdata2_i    (tdata2),
    .mte_i       (mte),
    .bp_hit_o    (bp_hit)
  );

  trap_ctrl u_trap (
    .bp_hit_i      (bp_hit),
    .retire_pc_i   (retire_pc_i),
    .csr_illegal_i (csr_illegal),
    .csr_addr_i    (csr_addr_i),
    .exc_i         (exc_i),
    .exc_cause_i   (exc_cause_i),
    .exc_pc_i      (exc_pc_i),
    .exc_tval_i    (exc_tval_i),
    .mret_i        (mret_i),
    .mtvec_i       (mtvec),
    .mepc_i        (mepc),
    .trap_o        (trap_o),
    .trap_cause_o  (trap_cause),
    .trap_epc_o    (trap_epc),
    .trap_tval_o   (trap_tval),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

`default_nettype wire

//--- logic/hw_trigger.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module hw_trigger
  import csr_pkg::*;
(
  input  logic             retire_i,
  input  logic [`XLEN-1:0] retire_pc_i,
  input  tdata1_u          tdata1_i,
  input  logic [`XLEN-1:0] tdata2_i,
  input  logic             mte_i,
  output logic             bp_hit_o
);

  logic type_ok;   // mcontrol and not debug-owned
  logic armed;     // Enables line up for M-mode execute
  logic pc_match;

  // ==========================================================
  // mcontrol decode
  // ==========================================================
  always_comb begin
    type_ok = (tdata1_i.mc.tdata_type == `MCONTROL_TYPE) && !tdata1_i.mc.dmode;
    armed   = tdata1_i.mc.m && tdata1_i.mc.execute
              && mte_i;  // Cleared while inside a trap handler
  end

  // Exact address compare
  assign pc_match = (retire_pc_i == tdata2_i);

  // Fires on the retiring instruction only
  assign bp_hit_o = retire_i && type_ok && armed && pc_match;

endmodule

`default_nettype wire

//--- logic/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module trap_ctrl
  import csr_pkg::*;
(
  input  logic             bp_hit_i,
  input  logic [`XLEN-1:0] retire_pc_i,
  input  logic             csr_illegal_i,
  input  logic [11:0]      csr_addr_i,
  input  logic             exc_i,
  input  exc_cause_e       exc_cause_i,
  input  logic [`XLEN-1:0] exc_pc_i,
  input  logic [`XLEN-1:0] exc_tval_i,
  input  logic             mret_i,
  input  logic [`XLEN-1:0] mtvec_i,
  input  logic [`XLEN-1:0] mepc_i,
  output logic             trap_o,
  output exc_cause_e       trap_cause_o,
  output logic [`XLEN-1:0] trap_epc_o,
  output logic [`XLEN-1:0] trap_tval_o,
  output logic             redirect_o,
  output logic [`XLEN-1:0] redirect_pc_o
);

  // ==========================================================
  // Cause select
  // ==========================================================
  always_comb begin
    trap_o       = 1'b0;
    trap_cause_o = exc_cause_i;
    trap_epc_o   = exc_pc_i;
    trap_tval_o  = exc_tval_i;
    if (bp_hit_i) begin  // Breakpoint first
      trap_o       = 1'b1;
      trap_cause_o = EXC_BREAKPOINT;
      trap_epc_o   = retire_pc_i;
      trap_tval_o  = retire_pc_i;  // tval is the matching PC
    end else if (csr_illegal_i) begin
      trap_o       = 1'b1;
      trap_cause_o = EXC_ILLEGAL;
      trap_epc_o   = exc_pc_i;
      // Offending CSR address
      trap_tval_o  = {{(`XLEN-12){1'b0}}, csr_addr_i};
    end else if (exc_i) begin
      trap_o = 1'b1;  // Core's own cause passes through
    end
  end

  // Fetch redirect
  // Direct mode only so the low bits are dropped
  assign redirect_o    = mret_i && !trap_o;
  assign redirect_pc_o = trap_o ? {mtvec_i[`XLEN-1:2], 2'b00} : mepc_i;

endmodule

`default_nettype wire

//--- logic/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_regs
  import csr_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [11:0]      csr_addr_i,
  input  logic             csr_req_i,
  input  logic             csr_we_i,
  input  logic [`XLEN-1:0] csr_wdata_i,
  output logic [`XLEN-1:0] csr_rdata_o,
  output logic             csr_illegal_o,
  input  logic             trap_i,
  input  exc_cause_e       trap_cause_i,
  input  logic [`XLEN-1:0] trap_epc_i,
  input  logic [`XLEN-1:0] trap_tval_i,
  input  logic             mret_i,
  input  logic             retire_i,
  output logic [`XLEN-1:0] mtvec_o,
  output logic [`XLEN-1:0] mepc_o,
  output logic             misa_c_o,
  output tdata1_u          tdata1_o,
  output logic [`XLEN-1:0] tdata2_o,
  output logic             mte_o
);

  // ==========================================================
  // State
  // ==========================================================
  logic             mstatus_mie_q;
  logic             mstatus_mpie_q;
  logic [`XLEN-1:0] misa_q;
  logic [`XLEN-1:0] mie_q;
  logic [`XLEN-1:0] mtvec_q;
  logic [`XLEN-1:0] mscratch_q;
  logic [`XLEN-1:0] mepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic [`XLEN-1:0] mtval_q;
  logic [63:0]      mcycle_q;    // {mcycleh, mcycle}
  logic [63:0]      minstret_q;  // {minstreth, minstret}
  logic [`XLEN-1:0] pmpcfg0_q;
  logic [`XLEN-1:0] pmpaddr0_q;
  tdata1_u          tdata1_q;
  logic [`XLEN-1:0] tdata2_q;
  logic             mte_q;       // tcontrol bit 3
  logic             mpte_q;      // tcontrol bit 7

  logic             csr_implemented;
  logic             csr_wr;      // Write that actually lands
  logic             instret_wr;
  tdata1_u          tdata1_wview;
  tdata1_u          tdata1_next;

  // ==========================================================
  // Read mux and legality
  // ==========================================================
  always_comb begin
    csr_implemented = 1'b1;
    case (csr_addr_i)
      `CSR_MSTATUS:   csr_rdata_o = {19'b0, 2'b11, 3'b0, mstatus_mpie_q, 3'b0,
                                     mstatus_mie_q, 3'b0};  // MPP fixed at M
      `CSR_MISA:      csr_rdata_o = misa_q;
      `CSR_MIE:       csr_rdata_o = mie_q;
      `CSR_MTVEC:     csr_rdata_o = mtvec_q;
      `CSR_MSCRATCH:  csr_rdata_o = mscratch_q;
      `CSR_MEPC:      csr_rdata_o = mepc_q;
      `CSR_MCAUSE:    csr_rdata_o = mcause_q;
      `CSR_MTVAL:     csr_rdata_o = mtval_q;
      `CSR_MCYCLE,
      `CSR_CYCLE:     csr_rdata_o = mcycle_q[31:0];
      `CSR_MCYCLEH,
      `CSR_CYCLEH:    csr_rdata_o = mcycle_q[63:32];
      `CSR_MINSTRET,
      `CSR_INSTRET:   csr_rdata_o = minstret_q[31:0];
      `CSR_MINSTRETH,
      `CSR_INSTRETH:  csr_rdata_o = minstret_q[63:32];
      `CSR_PMPCFG0:   csr_rdata_o = pmpcfg0_q;
      `CSR_PMPADDR0:  csr_rdata_o = pmpaddr0_q;
      `CSR_TDATA1:    csr_rdata_o = tdata1_q.raw;
      `CSR_TDATA2:    csr_rdata_o = tdata2_q;
      `CSR_TCONTROL:  csr_rdata_o = {24'b0, mpte_q, 3'b0, mte_q, 3'b0};
      // Hardwired zero group (no interrupts, one trigger, ID regs)
      `CSR_MIP,
      `CSR_TSELECT,
      `CSR_MVENDORID,
      `CSR_MARCHID,
      `CSR_MHARTID:   csr_rdata_o = '0;
      default: begin
        csr_rdata_o     = '0;
        csr_implemented = 1'b0;
      end
    endcase
  end

  // Bits 11:10 == 3 marks a read-only address
  assign csr_illegal_o = csr_req_i &&
                         (!csr_implemented || (csr_we_i && csr_addr_i[11:10] == 2'b11));

  // Trap beats MRET, MRET beats the write
  assign csr_wr     = csr_req_i && csr_we_i && !csr_illegal_o && !trap_i && !mret_i;
  assign instret_wr = csr_wr &&
                      (csr_addr_i == `CSR_MINSTRET || csr_addr_i == `CSR_MINSTRETH);

  // tdata1 WARL through the mcontrol view
  assign tdata1_wview.raw = csr_wdata_i;
  always_comb begin
    tdata1_next            = '0;
    tdata1_next.mc.tdata_type = `MCONTROL_TYPE;  // Type is pinned
    tdata1_next.mc.m       = tdata1_wview.mc.m;
    tdata1_next.mc.execute = tdata1_wview.mc.execute;
  end

  // ==========================================================
  // Update
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      misa_q         <= `MISA_RESET;
      mie_q          <= '0;
      mtvec_q        <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mcycle_q       <= '0;
      minstret_q     <= '0;
      pmpcfg0_q      <= '0;
      pmpaddr0_q     <= '0;
      tdata1_q.raw   <= `TDATA1_RESET;
      tdata2_q       <= '0;
      mte_q          <= 1'b0;
      mpte_q         <= 1'b0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;  // Free running
      if (retire_i && !trap_i && !instret_wr) begin
        minstret_q <= minstret_q + 64'd1;
      end

      if (trap_i) begin
        mepc_q         <= trap_epc_i;
        mcause_q       <= {{(`XLEN-4){1'b0}}, trap_cause_i};
        mtval_q        <= trap_tval_i;
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
        mpte_q         <= mte_q;
        mte_q          <= 1'b0;  // Trigger off in handler
      end else if (mret_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
        mte_q          <= mpte_q;
        mpte_q         <= 1'b0;
      end else if (csr_wr) begin
        case (csr_addr_i)
          `CSR_MSTATUS: begin
            mstatus_mie_q  <= csr_wdata_i[3];
            mstatus_mpie_q <= csr_wdata_i[7];
          end
          `CSR_MISA:      misa_q <= (misa_q & ~`MISA_WMASK) | (csr_wdata_i & `MISA_WMASK);
          `CSR_MIE:       mie_q      <= csr_wdata_i & `MIE_WMASK;
          `CSR_MTVEC:     mtvec_q    <= csr_wdata_i;
          `CSR_MSCRATCH:  mscratch_q <= csr_wdata_i;
          `CSR_MEPC:      mepc_q     <= csr_wdata_i;
          `CSR_MCAUSE:    mcause_q   <= csr_wdata_i;
          `CSR_MTVAL:     mtval_q    <= csr_wdata_i;
          `CSR_MCYCLE:    mcycle_q[31:0]    <= csr_wdata_i;  // Overrides increment
          `CSR_MCYCLEH:   mcycle_q[63:32]   <= csr_wdata_i;
          `CSR_MINSTRET:  minstret_q[31:0]  <= csr_wdata_i;
          `CSR_MINSTRETH: minstret_q[63:32] <= csr_wdata_i;
          `CSR_PMPCFG0:   pmpcfg0_q  <= csr_wdata_i;
          `CSR_PMPADDR0:  pmpaddr0_q <= csr_wdata_i;
          `CSR_TDATA1:    tdata1_q   <= tdata1_next;
          `CSR_TDATA2:    tdata2_q   <= csr_wdata_i;
          `CSR_TCONTROL: begin
            mte_q  <= csr_wdata_i[3];
            mpte_q <= csr_wdata_i[7];
          end
          default: ;  // mip, tselect and ID regs ignore writes
        endcase
      end
    end
  end

  assign mtvec_o  = mtvec_q;
  assign mepc_o   = mepc_q;
  assign misa_c_o = misa_q[2];
  assign tdata1_o = tdata1_q;
  assign tdata2_o = tdata2_q;
  assign mte_o    = mte_q;

endmodule

`default_nettype wire

//--- logic/csr_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_op_decode
  import csr_pkg::*;
(
  input  logic             csr_req_i,
  input  csr_op_e          csr_op_i,
  input  logic [`XLEN-1:0] csr_src_i,
  input  logic [`XLEN-1:0] csr_old_i,
  output logic             csr_we_o,
  output logic [`XLEN-1:0] csr_wdata_o
);

  logic             imm_form;  // Immediate variants
  logic [`XLEN-1:0] operand;
  logic             operand_nz;

  always_comb begin
    imm_form = csr_op_i inside {CSR_RWI, CSR_RSI, CSR_RCI};
    // uimm is rs1 field, zero-extended
    operand = imm_form ? {{(`XLEN-5){1'b0}}, csr_src_i[4:0]} : csr_src_i;
    operand_nz = |operand;
  end

  // ==========================================================
  // New value and write enable
  // ==========================================================
  always_comb begin
    csr_wdata_o = csr_old_i;  // Hold by default
    csr_we_o    = 1'b0;
    case (csr_op_i)
      CSR_RW, CSR_RWI: begin
        csr_wdata_o = operand;  // Plain replace
        csr_we_o    = csr_req_i;
      end
      CSR_RS, CSR_RSI: begin
        csr_wdata_o = csr_old_i | operand;
        // Zero source means read only
        csr_we_o    = csr_req_i && operand_nz;
      end
      CSR_RC, CSR_RCI: begin
        csr_wdata_o = csr_old_i & ~operand;
        csr_we_o    = csr_req_i && operand_nz;
      end
      default: begin
        csr_wdata_o = csr_old_i;  // CSR_NONE
        csr_we_o    = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

  // CSR instruction flavours
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd5,
    CSR_RSI  = 3'd6,
    CSR_RCI  = 3'd7
  } csr_op_e;

  // Synchronous exception codes (mcause, interrupt bit clear)
  typedef enum logic [3:0] {
    EXC_IADDR_MISALIGN = 4'd0,
    EXC_IACCESS        = 4'd1,
    EXC_ILLEGAL        = 4'd2,
    EXC_BREAKPOINT     = 4'd3,
    EXC_LADDR_MISALIGN = 4'd4,
    EXC_LACCESS        = 4'd5,
    EXC_SADDR_MISALIGN = 4'd6,
    EXC_SACCESS        = 4'd7,
    EXC_ECALL_M        = 4'd11
  } exc_cause_e;

  // ==========================================================
  // tdata1 as mcontrol (RV32 layout)
  // ==========================================================
  typedef struct packed {
    logic [3:0] tdata_type;  // 2 = mcontrol
    logic       dmode;
    logic [5:0] maskmax;
    logic       hit;
    logic       select;
    logic       timing;
    logic [1:0] sizelo;
    logic [3:0] action;
    logic       chain;
    logic [3:0] match;
    logic       m;           // Fire in M-mode
    logic       rsvd;
    logic       s;
    logic       u;
    logic       execute;     // Match on fetch address
    logic       store;
    logic       load;
  } mcontrol_t;

  typedef union packed {
    logic [`XLEN-1:0] raw;
    mcontrol_t        mc;
  } tdata1_u;

endpackage

`default_nettype wire

//--- logic/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// ==========================================================
// Data width
// ==========================================================
`define XLEN 32

// ==========================================================
// CSR addresses
// ==========================================================
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_PMPCFG0   12'h3A0
`define CSR_PMPADDR0  12'h3B0
`define CSR_TSELECT   12'h7A0
`define CSR_TDATA1    12'h7A1
`define CSR_TDATA2    12'h7A2
`define CSR_TCONTROL  12'h7A5
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_CYCLE     12'hC00  // User aliases are read only
`define CSR_INSTRET   12'hC02
`define CSR_CYCLEH    12'hC80
`define CSR_INSTRETH  12'hC82
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MHARTID   12'hF14

// ==========================================================
// Reset values and WARL masks
// ==========================================================
`define MISA_RESET    32'h4000_1104  // MXL=1, I, M, C
`define MISA_WMASK    32'h0000_0004  // C bit only
`define MIE_WMASK     32'h0000_0888  // MSIE, MTIE, MEIE
`define TDATA1_RESET  32'h2000_0044  // mcontrol with m and execute
`define MCONTROL_TYPE 4'd2

`endif
